// ==== Makefile ====
TOP := tb_st_glue

.PHONY: compile run clean

compile:
	verilator --binary --timing --timescale 1ns/100ps -f compile.f --top-module $(TOP) -o V$(TOP)

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
+incdir+.
st_glue_pkg.sv
st_glue_regs.sv
ste_joypad.sv
st_mem_decode.sv
st_audio_mix.sv
st_glue_top.sv
tb_clock_gen.sv
tb_st_glue.sv

// ==== st_audio_mix.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "st_glue_consts.svh"

module st_audio_mix (
	input  wire                  clk_32,
	input  wire                  xsint,
	input  wire [`ST_YM_W-1:0]   ym_l_i,
	input  wire [`ST_YM_W-1:0]   ym_r_i,
	input  wire [`ST_DMA_W-1:0]  dma_l_i,
	input  wire [`ST_DMA_W-1:0]  dma_r_i,
	output logic [`ST_MIX_W-1:0] audio_l_o,
	output logic [`ST_MIX_W-1:0] audio_r_o
);

	// one channel: remove the midpoints, scale both to 15 bits, add
	function automatic logic [`ST_MIX_W-1:0] mix_chan(
		input logic [`ST_YM_W-1:0]  ym,
		input logic [`ST_DMA_W-1:0] dma
	);
		logic [`ST_YM_W-1:0]  s_ym;
		logic [`ST_DMA_W-1:0] s_dma;
		s_ym  = ym - `ST_YM_W'(`ST_YM_BIAS);
		s_dma = dma - `ST_DMA_W'(`ST_DMA_BIAS);
		// low bits refilled from the msbs for a near full scale range
		return {s_ym[9], s_ym, s_ym[9:6]} + {s_dma[7], s_dma, s_dma[7:2]};
	endfunction

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			audio_l_o <= '0;
			audio_r_o <= '0;
		end else begin
			audio_l_o <= mix_chan(ym_l_i, dma_l_i);
			audio_r_o <= mix_chan(ym_r_i, dma_r_i);
		end
	end

endmodule

`default_nettype wire

// ==== st_glue_consts.svh ====
`ifndef ST_GLUE_CONSTS_SVH
`define ST_GLUE_CONSTS_SVH

// shared widths and constants of the ste chipset glue

// bus word address, bits 23 down to 1
`define ST_ADDR_W 23

// apb register port
`define ST_APB_AW 8
`define ST_APB_DW 16

// sample widths
// ym2149 output, unsigned
`define ST_YM_W 10
// dma sound output, unsigned
`define ST_DMA_W 8
// mixed signed output
`define ST_MIX_W 15

// midpoints of the unsigned sources
`define ST_YM_BIAS 512
`define ST_DMA_BIAS 128

// joypad select latch after reset, all rows deselected
`define ST_JOY_OUT_RST 8'hFF

// one joystick input word from the host
`define ST_JOY_W 16

`endif

// ==== st_glue_pkg.sv ====
`default_nettype none

`include "st_glue_consts.svh"

package st_glue_pkg;

	// ram size code as held in the system config register
	// codes 6 and 7 are stored as is and disable all ram
	typedef enum logic [2:0] {
		RAM_512K = 3'd0,
		RAM_1M   = 3'd1,
		RAM_2M   = 3'd2,
		RAM_4M   = 3'd3,
		RAM_8M   = 3'd4,
		RAM_14M  = 3'd5
	} ram_size_e;

	// apb register offsets
	typedef enum logic [`ST_APB_AW-1:0] {
		REG_SYS_CFG    = 8'h00,
		REG_CACHE_CTRL = 8'h04,
		REG_JOY_OUT    = 8'h08,
		// read only, live joypad ports
		REG_JOY_IN     = 8'h0C
	} reg_addr_e;

endpackage

`default_nettype wire

// ==== st_glue_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "st_glue_consts.svh"

module st_glue_regs import st_glue_pkg::*; (
	input  wire                  clk_32,
	input  wire                  xsint,
	// apb slave
	input  wire                  psel_i,
	input  wire                  penable_i,
	input  wire                  pwrite_i,
	input  wire [`ST_APB_AW-1:0] paddr_i,
	input  wire [`ST_APB_DW-1:0] pwdata_i,
	output logic [`ST_APB_DW-1:0] prdata_o,
	output logic                 pready_o,
	output logic                 pslverr_o,
	// live joypad port readback
	input  wire [3:0]            pad0_dout_i,
	input  wire [1:0]            pad0_btn_i,
	input  wire [3:0]            pad1_dout_i,
	input  wire [1:0]            pad1_btn_i,
	// configuration outputs
	output ram_size_e            ram_size_o,
	output logic                 tos192k_o,
	output logic                 cache_en_o,
	output logic                 cpu_16mhz_o,
	output logic [7:0]           joy_sel_o
);

	logic                  access;
	logic                  addr_ok;
	logic                  wr_en;
	logic [`ST_APB_DW-1:0] joy_in_word;
	logic [`ST_APB_DW-1:0] rd_data;

	// second phase of a transfer, never stretched
	assign access   = psel_i & penable_i;
	assign pready_o = access;

	// pads side by side, buttons above the direction bits
	assign joy_in_word = {4'h0, pad1_btn_i, pad0_btn_i, pad1_dout_i, pad0_dout_i};

	// offset decode and read mux
	always_comb begin
		addr_ok = 1'b1;
		rd_data = '0;
		case (reg_addr_e'(paddr_i))
			REG_SYS_CFG: begin
				rd_data[3:0] = {tos192k_o, ram_size_o};
			end
			REG_CACHE_CTRL: begin
				rd_data[1:0] = {cache_en_o, cpu_16mhz_o};
			end
			REG_JOY_OUT: begin
				rd_data[7:0] = joy_sel_o;
			end
			REG_JOY_IN: begin
				rd_data = joy_in_word;
			end
			default: begin
				addr_ok = 1'b0;
			end
		endcase
	end

	// unknown offset, or a write to the read-only port
	assign pslverr_o = access & (~addr_ok | (pwrite_i & (paddr_i == REG_JOY_IN)));

	// data only while the access phase is up
	assign prdata_o = access ? rd_data : '0;

	// a flagged write is dropped
	assign wr_en = access & pwrite_i & ~pslverr_o;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ram_size_o  <= RAM_512K;
			tos192k_o   <= 1'b0;
			cache_en_o  <= 1'b0;
			cpu_16mhz_o <= 1'b0;
			joy_sel_o   <= `ST_JOY_OUT_RST;
		end else if (wr_en) begin
			case (reg_addr_e'(paddr_i))
				REG_SYS_CFG: begin
					// size codes 6 and 7 kept, they mean no ram
					ram_size_o <= ram_size_e'(pwdata_i[2:0]);
					tos192k_o  <= pwdata_i[3];
				end
				REG_CACHE_CTRL: begin
					cpu_16mhz_o <= pwdata_i[0];
					cache_en_o  <= pwdata_i[1];
				end
				REG_JOY_OUT: begin
					joy_sel_o <= pwdata_i[7:0];
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== st_glue_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "st_glue_consts.svh"

module st_glue_top import st_glue_pkg::*; (
	input  wire                  clk_32,
	input  wire                  xsint,
	// apb register port
	input  wire                  psel_i,
	input  wire                  penable_i,
	input  wire                  pwrite_i,
	input  wire [`ST_APB_AW-1:0] paddr_i,
	input  wire [`ST_APB_DW-1:0] pwdata_i,
	output wire [`ST_APB_DW-1:0] prdata_o,
	output wire                  pready_o,
	output wire                  pslverr_o,
	// mega ste speed control
	output wire                  cache_en_o,
	output wire                  cpu_16mhz_o,
	// ste joypad ports
	input  wire [`ST_JOY_W-1:0]  joy0_i,
	input  wire [`ST_JOY_W-1:0]  joy1_i,
	// memory bus
	input  wire [`ST_ADDR_W:1]   bus_addr_i,
	input  wire                  rom_sel_i,
	input  wire                  ram_req_i,
	output wire [`ST_ADDR_W:1]   sdram_addr_o,
	output wire                  sdram_req_o,
	// audio
	input  wire [`ST_YM_W-1:0]   ym_l_i,
	input  wire [`ST_YM_W-1:0]   ym_r_i,
	input  wire [`ST_DMA_W-1:0]  dma_l_i,
	input  wire [`ST_DMA_W-1:0]  dma_r_i,
	output wire [`ST_MIX_W-1:0]  audio_l_o,
	output wire [`ST_MIX_W-1:0]  audio_r_o
);

	ram_size_e  ram_size;
	wire        tos192k;
	wire [7:0]  joy_sel;
	wire [3:0]  pad0_dout;
	wire [1:0]  pad0_btn;
	wire [3:0]  pad1_dout;
	wire [1:0]  pad1_btn;

	st_glue_regs i_regs (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.paddr_i     (paddr_i),
		.pwdata_i    (pwdata_i),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o),
		.pslverr_o   (pslverr_o),
		.pad0_dout_i (pad0_dout),
		.pad0_btn_i  (pad0_btn),
		.pad1_dout_i (pad1_dout),
		.pad1_btn_i  (pad1_btn),
		.ram_size_o  (ram_size),
		.tos192k_o   (tos192k),
		.cache_en_o  (cache_en_o),
		.cpu_16mhz_o (cpu_16mhz_o),
		.joy_sel_o   (joy_sel)
	);

	// low latch nibble scans pad 0, high nibble pad 1
	ste_joypad i_pad0 (
		.joy_i     (joy0_i),
		.sel_i     (joy_sel[3:0]),
		.dout_o    (pad0_dout),
		.buttons_o (pad0_btn)
	);

	ste_joypad i_pad1 (
		.joy_i     (joy1_i),
		.sel_i     (joy_sel[7:4]),
		.dout_o    (pad1_dout),
		.buttons_o (pad1_btn)
	);

	st_mem_decode i_mem_decode (
		.clk_32       (clk_32),
		.xsint        (xsint),
		.bus_addr_i   (bus_addr_i),
		.rom_sel_i    (rom_sel_i),
		.ram_req_i    (ram_req_i),
		.ram_size_i   (ram_size),
		.tos192k_i    (tos192k),
		.sdram_addr_o (sdram_addr_o),
		.sdram_req_o  (sdram_req_o)
	);

	st_audio_mix i_audio_mix (
		.clk_32    (clk_32),
		.xsint     (xsint),
		.ym_l_i    (ym_l_i),
		.ym_r_i    (ym_r_i),
		.dma_l_i   (dma_l_i),
		.dma_r_i   (dma_r_i),
		.audio_l_o (audio_l_o),
		.audio_r_o (audio_r_o)
	);

endmodule

`default_nettype wire

// ==== st_mem_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "st_glue_consts.svh"

module st_mem_decode import st_glue_pkg::*; (
	input  wire                 clk_32,
	input  wire                 xsint,
	input  wire [`ST_ADDR_W:1]  bus_addr_i,
	input  wire                 rom_sel_i,
	input  wire                 ram_req_i,
	input  ram_size_e           ram_size_i,
	input  wire                 tos192k_i,
	output logic [`ST_ADDR_W:1] sdram_addr_o,
	output logic                sdram_req_o
);

	logic                ram_en;
	logic [`ST_ADDR_W:1] addr_nxt;

	// ram window per configured size
	always_comb begin
		case (ram_size_i)
			RAM_512K: ram_en = (bus_addr_i[23:19] == 5'b00000);
			RAM_1M:   ram_en = (bus_addr_i[23:20] == 4'b0000);
			RAM_2M:   ram_en = (bus_addr_i[23:21] == 3'b000);
			RAM_4M:   ram_en = (bus_addr_i[23:22] == 2'b00);
			RAM_8M:   ram_en = ~bus_addr_i[23];
			// everything below $c00000 plus $c00000-$dfffff
			RAM_14M: begin
				ram_en = ~(bus_addr_i[23] & bus_addr_i[22]) |
					(bus_addr_i[23:21] == 3'b110);
			end
			// codes 6 and 7 map no ram at all
			default:  ram_en = 1'b0;
		endcase
	end

	// rom fetches land in the tos image area of sdram
	// 192k tos lives at $fc0000 and newer tos at $e00000
	always_comb begin
		if (!rom_sel_i) begin
			addr_nxt = bus_addr_i;
		end else if (tos192k_i) begin
			addr_nxt = {4'hF, 2'b11, bus_addr_i[17:1]};
		end else begin
			addr_nxt = {4'hE, 2'b00, bus_addr_i[17:1]};
		end
	end

	// ram request inside the configured window
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			sdram_req_o <= 1'b0;
		end else begin
			sdram_req_o <= ram_req_i & ~rom_sel_i & ram_en;
		end
	end

	// address follows every cycle
	always_ff @(posedge clk_32) begin
		sdram_addr_o <= addr_nxt;
	end

endmodule

`default_nettype wire

// ==== ste_joypad.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "st_glue_consts.svh"

module ste_joypad (
	input  wire [`ST_JOY_W-1:0] joy_i,
	input  wire [3:0]           sel_i,
	output logic [3:0]          dout_o,
	output logic [1:0]          buttons_o
);

	// open collector row scan
	// a low select line pulls the pressed keys of its row low
	always_comb begin
		dout_o = 4'hF;
		for (int k = 0; k < 4; k++) begin
			if (!sel_i[k]) begin
				dout_o = dout_o & ~joy_i[4*k +: 4];
			end
		end
	end

	// fire buttons sit on the first two rows only
	// pressed and selected gives a low line
	assign buttons_o[0] = ~(~sel_i[0] & joy_i[4]);
	assign buttons_o[1] = ~(~sel_i[1] & joy_i[5]);

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic clk_32,
	output logic xsint
);

	// 32 mhz domain stand-in, 20 ns period
	initial begin
		clk_32 = 1'b0;
		forever #10 clk_32 = ~clk_32;
	end

	// reset held over the first three rising edges
	initial begin
		xsint = 1'b0;
		repeat (3) @(posedge clk_32);
		#2;
		xsint = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb_st_glue.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "st_glue_consts.svh"

module tb_st_glue import st_glue_pkg::*; ();

	localparam int N_REG = 200;
	localparam int N_ERR = 40;
	localparam int N_JOY = 100;
	localparam int N_CFG = 16;
	localparam int N_MEM = 25;
	localparam int N_AUD = 300;
	// apb transfers of two clocks each
	localparam int N_XFER = 3 + N_REG * 4 + N_ERR * 5 + N_JOY * 2 + N_CFG;
	localparam int N_SAMPLE = N_CFG * N_MEM + N_AUD + 10;
	localparam int WD_NS = (2 * N_XFER + N_SAMPLE) * 20 * 2;

	wire                   clk_32;
	wire                   xsint;
	logic                  psel_i;
	logic                  penable_i;
	logic                  pwrite_i;
	logic [`ST_APB_AW-1:0] paddr_i;
	logic [`ST_APB_DW-1:0] pwdata_i;
	wire  [`ST_APB_DW-1:0] prdata_o;
	wire                   pready_o;
	wire                   pslverr_o;
	wire                   cache_en_o;
	wire                   cpu_16mhz_o;
	logic [`ST_JOY_W-1:0]  joy0_i;
	logic [`ST_JOY_W-1:0]  joy1_i;
	logic [`ST_ADDR_W:1]   bus_addr_i;
	logic                  rom_sel_i;
	logic                  ram_req_i;
	wire  [`ST_ADDR_W:1]   sdram_addr_o;
	wire                   sdram_req_o;
	logic [`ST_YM_W-1:0]   ym_l_i;
	logic [`ST_YM_W-1:0]   ym_r_i;
	logic [`ST_DMA_W-1:0]  dma_l_i;
	logic [`ST_DMA_W-1:0]  dma_r_i;
	wire  [`ST_MIX_W-1:0]  audio_l_o;
	wire  [`ST_MIX_W-1:0]  audio_r_o;

	integer seed = 71348;
	int     errors = 0;
	// register model
	logic [2:0] m_ram;
	logic       m_tos;
	logic       m_cache;
	logic       m_16m;
	logic [7:0] m_joy;

	tb_clock_gen i_clk_gen (.clk_32(clk_32), .xsint(xsint));

	st_glue_top i_dut (.*);

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	// setup then access phase entered and left 2 ns after an edge
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [15:0] wdata,
			input logic exp_err, output logic [15:0] rdata);
		psel_i = 1'b1;
		penable_i = 1'b0;
		pwrite_i = wr;
		paddr_i = addr;
		pwdata_i = wdata;
		@(posedge clk_32);
		#2;
		penable_i = 1'b1;
		// sampled mid access phase where everything has settled
		@(negedge clk_32);
		check_value("pready_o", 32'(pready_o), 32'd1);
		check_value("pslverr_o", 32'(pslverr_o), 32'(exp_err));
		rdata = prdata_o;
		@(posedge clk_32);
		#2;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
	endtask

	task automatic reg_write(input logic [7:0] addr, input logic [15:0] data);
		logic [15:0] rd;
		apb_xfer(1'b1, addr, data, 1'b0, rd);
		case (addr)
			REG_SYS_CFG: begin
				m_ram = data[2:0];
				m_tos = data[3];
			end
			REG_CACHE_CTRL: begin
				m_16m = data[0];
				m_cache = data[1];
			end
			REG_JOY_OUT: begin
				m_joy = data[7:0];
			end
			default: begin
			end
		endcase
		// speed outputs already follow the write
		check_value("cache_en_o", 32'(cache_en_o), 32'(m_cache));
		check_value("cpu_16mhz_o", 32'(cpu_16mhz_o), 32'(m_16m));
	endtask

	task automatic check_regs();
		logic [15:0] rd;
		apb_xfer(1'b0, REG_SYS_CFG, 16'h0000, 1'b0, rd);
		check_value("REG_SYS_CFG", 32'(rd), 32'({m_tos, m_ram}));
		apb_xfer(1'b0, REG_CACHE_CTRL, 16'h0000, 1'b0, rd);
		check_value("REG_CACHE_CTRL", 32'(rd), 32'({m_cache, m_16m}));
		apb_xfer(1'b0, REG_JOY_OUT, 16'h0000, 1'b0, rd);
		check_value("REG_JOY_OUT", 32'(rd), 32'(m_joy));
	endtask

	// any selected row with the key pressed pulls the line low
	function automatic logic [3:0] pad_data(input logic [15:0] joy, input logic [3:0] sel);
		logic [3:0] d;
		d = 4'hF;
		for (int b = 0; b < 4; b++) begin
			for (int k = 0; k < 4; k++) begin
				if (!sel[k] && joy[4*k+b]) begin
					d[b] = 1'b0;
				end
			end
		end
		return d;
	endfunction

	function automatic logic [1:0] pad_buttons(input logic [15:0] joy, input logic [3:0] sel);
		logic [1:0] b;
		b = 2'b11;
		if (!sel[0] && joy[4]) begin
			b[0] = 1'b0;
		end
		if (!sel[1] && joy[5]) begin
			b[1] = 1'b0;
		end
		return b;
	endfunction

	// returns {req, word address} worked out on byte addresses
	function automatic logic [23:0] decode_model(input logic [23:1] addr, input logic rom,
			input logic req, input logic [2:0] size, input logic tos);
		logic [23:0] byte_a;
		logic [23:0] limit;
		logic [23:0] out_a;
		byte_a = {addr, 1'b0};
		case (size)
			3'd0: limit = 24'h080000;
			3'd1: limit = 24'h100000;
			3'd2: limit = 24'h200000;
			3'd3: limit = 24'h400000;
			3'd4: limit = 24'h800000;
			// 14M ends below $e00000
			3'd5: limit = 24'hE00000;
			default: limit = 24'h000000;
		endcase
		if (!rom) begin
			out_a = byte_a;
		end else if (tos) begin
			out_a = 24'hFC0000 | (byte_a & 24'h03FFFF);
		end else begin
			out_a = 24'hE00000 | (byte_a & 24'h03FFFF);
		end
		return {req && !rom && (byte_a < limit), out_a[23:1]};
	endfunction

	// signed sample times 2^k plus the top bits of the offset code
	function automatic logic [14:0] mix_model(input logic [9:0] ym, input logic [7:0] dma);
		int ym_w;
		int dma_w;
		int sum;
		ym_w = (int'(ym) - `ST_YM_BIAS) * 16 + int'((ym ^ 10'h200) >> 6);
		dma_w = (int'(dma) - `ST_DMA_BIAS) * 64 + int'((dma ^ 8'h80) >> 2);
		sum = ym_w + dma_w;
		return sum[14:0];
	endfunction

	initial begin
		#(WD_NS);
		$display("timeout, the tests did not complete in time");
		$display("Verification failed");
		$fatal(1);
	end

	initial begin
		logic [31:0] r;
		logic [15:0] rd;
		logic [7:0]  off;
		logic [23:0] exp_mem;
		logic [14:0] exp_l;
		logic [14:0] exp_r;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = '0;
		pwdata_i = '0;
		joy0_i = '0;
		joy1_i = '0;
		bus_addr_i = '0;
		rom_sel_i = 1'b0;
		// busy memory and audio inputs while reset is held
		ram_req_i = 1'b1;
		ym_l_i = 10'h3FF;
		ym_r_i = 10'h000;
		dma_l_i = 8'hFF;
		dma_r_i = 8'h00;
		m_ram = 3'd0;
		m_tos = 1'b0;
		m_cache = 1'b0;
		m_16m = 1'b0;
		m_joy = `ST_JOY_OUT_RST;
		@(posedge xsint);
		// reset values before the first edge out of reset
		@(negedge clk_32);
		check_value("cache_en_o", 32'(cache_en_o), 32'd0);
		check_value("cpu_16mhz_o", 32'(cpu_16mhz_o), 32'd0);
		check_value("sdram_req_o", 32'(sdram_req_o), 32'd0);
		check_value("audio_l_o", 32'(audio_l_o), 32'd0);
		check_value("audio_r_o", 32'(audio_r_o), 32'd0);
		@(posedge clk_32);
		#2;
		check_regs();
		// register round trip
		for (int i = 0; i < N_REG; i++) begin
			r = next_random();
			case (r[17:16])
				2'd0: off = REG_SYS_CFG;
				2'd1: off = REG_CACHE_CTRL;
				default: off = REG_JOY_OUT;
			endcase
			reg_write(off, r[15:0]);
			check_regs();
		end
		// bad offsets and writes to the read-only port
		for (int i = 0; i < N_ERR; i++) begin
			do begin
				r = next_random();
				off = r[7:0];
			end while (off == REG_SYS_CFG || off == REG_CACHE_CTRL || off == REG_JOY_OUT ||
				off == REG_JOY_IN);
			apb_xfer(r[8], off, r[31:16], 1'b1, rd);
			apb_xfer(1'b1, REG_JOY_IN, r[31:16], 1'b1, rd);
			check_regs();
		end
		// joypad readback
		for (int i = 0; i < N_JOY; i++) begin
			r = next_random();
			joy0_i = r[15:0];
			joy1_i = r[31:16];
			r = next_random();
			reg_write(REG_JOY_OUT, r[15:0]);
			apb_xfer(1'b0, REG_JOY_IN, 16'h0000, 1'b0, rd);
			check_value("REG_JOY_IN", 32'(rd), 32'({4'h0,
				pad_buttons(joy1_i, m_joy[7:4]), pad_buttons(joy0_i, m_joy[3:0]),
				pad_data(joy1_i, m_joy[7:4]), pad_data(joy0_i, m_joy[3:0])}));
		end
		// memory decode
		for (int c = 0; c < N_CFG; c++) begin
			r = next_random();
			// first eight configs walk every size code
			reg_write(REG_SYS_CFG, {12'h000, r[3], (c < 8) ? 3'(c) : r[2:0]});
			for (int i = 0; i < N_MEM; i++) begin
				r = next_random();
				// shortened addresses hit the small ram sizes too
				bus_addr_i = r[22:0] >> r[27:25];
				rom_sel_i = r[28];
				ram_req_i = r[29] | r[30];
				exp_mem = decode_model(bus_addr_i, rom_sel_i, ram_req_i, m_ram, m_tos);
				@(posedge clk_32);
				#2;
				check_value("sdram_addr_o", 32'(sdram_addr_o), 32'(exp_mem[22:0]));
				check_value("sdram_req_o", 32'(sdram_req_o), 32'(exp_mem[23]));
			end
		end
		// audio mix with the corners first
		for (int i = 0; i < N_AUD; i++) begin
			r = next_random();
			if (i < 4) begin
				ym_l_i = i[0] ? 10'h3FF : 10'h000;
				dma_l_i = i[1] ? 8'hFF : 8'h00;
				ym_r_i = i[1] ? 10'h3FF : 10'h000;
				dma_r_i = i[0] ? 8'hFF : 8'h00;
			end else begin
				ym_l_i = r[9:0];
				ym_r_i = r[19:10];
				dma_l_i = r[27:20];
				dma_r_i = {r[31:28], r[3:0]};
			end
			exp_l = mix_model(ym_l_i, dma_l_i);
			exp_r = mix_model(ym_r_i, dma_r_i);
			@(posedge clk_32);
			#2;
			check_value("audio_l_o", 32'(audio_l_o), 32'(exp_l));
			check_value("audio_r_o", 32'(audio_r_o), 32'(exp_r));
		end
		if (errors == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("Verification failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire
